//--- common/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// Raster, one pixel per clock
`define PPU_H_VISIBLE 256
`define PPU_H_TOTAL 320
`define PPU_HS_START 272
`define PPU_HS_LEN 24
`define PPU_V_VISIBLE 240
`define PPU_V_TOTAL 262
`define PPU_VS_START 244
`define PPU_VS_LEN 3

`define PPU_VRAM_DEPTH 16384
`define PPU_PAL_DEPTH 32
`define PPU_PAL_BASE 16'h3F00 // Palette window start in PPU space

`define PPU_REG_CTRL 0
`define PPU_REG_MASK 1
`define PPU_REG_STATUS 2
`define PPU_REG_ADDR 6
`define PPU_REG_DATA 7

`endif

//--- common/ppu_bus_pkg.sv
`default_nettype none
`include "ppu_settings.svh"

package ppu_bus_pkg;

	typedef logic [$clog2(`PPU_VRAM_DEPTH)-1:0] ppu_addr_t;

	// CTRL register, MSB first
	typedef struct packed {
		logic       nmi_en;    // Bit 7
		logic [1:0] spare_hi;  // Bits 6:5
		logic       bg_table;  // Bit 4, pattern table 0x1000
		logic       spare_mid; // Bit 3
		logic       incr32;    // Bit 2, DATA steps by 32
		logic [1:0] spare_lo;  // Bits 1:0
	} ctrl_t;

	// MASK register
	typedef struct packed {
		logic [3:0] spare_hi; // Bits 7:4
		logic       show_bg;  // Bit 3
		logic [2:0] spare_lo; // Bits 2:0
	} mask_t;

	// One CPU side memory access
	typedef struct packed {
		ppu_addr_t  addr;
		logic       we;
		logic [7:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- common/ppu_video_pkg.sv
`default_nettype none
`include "ppu_settings.svh"

package ppu_video_pkg;

	typedef logic [5:0] color_t; // Index into the master colour set
	typedef logic [$clog2(`PPU_PAL_DEPTH)-1:0] pal_addr_t;

	// Raster position as seen by the rest of the chip
	typedef struct packed {
		logic [8:0] hc;
		logic [8:0] vc;
		logic       visible;
		logic       in_vblank; // Memories belong to the CPU
	} beam_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Everything leaving on the video pins
	typedef struct packed {
		logic hs;      // Active low
		logic vs;      // Active low
		logic blank_n;
		rgb_t rgb;
	} vga_t;

endpackage

`default_nettype wire

//--- src/ppu_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_ram #(
	parameter type word_t = logic [7:0],
	parameter int DEPTH = `PPU_VRAM_DEPTH,
	localparam int AW = $clog2(DEPTH)
) (
	input  logic          clk,
	input  logic [AW-1:0] addr,
	input  logic          we,
	input  word_t         wdata,
	output word_t         rdata
);

	word_t mem [DEPTH];

	// Read sees the old word on a write to the same address
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- ppu_reg/ppu_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_reg (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cs,
	input  logic                   we,
	input  logic [2:0]             reg_addr,
	input  logic [7:0]             cpu_data_in,
	input  ppu_video_pkg::beam_t   beam,
	input  logic                   cpu_owns,
	input  logic [7:0]             vram_rdata,
	input  ppu_video_pkg::color_t  pal_rdata,
	output logic [7:0]             cpu_data_out,
	output ppu_bus_pkg::mem_req_t  cpu_req,
	output ppu_bus_pkg::ctrl_t     ctrl,
	output ppu_bus_pkg::mask_t     mask,
	output logic                   nmi
);

	import ppu_bus_pkg::*;

	localparam logic [2:0] REG_CTRL = 3'(`PPU_REG_CTRL);
	localparam logic [2:0] REG_MASK = 3'(`PPU_REG_MASK);
	localparam logic [2:0] REG_STATUS = 3'(`PPU_REG_STATUS);
	localparam logic [2:0] REG_ADDR = 3'(`PPU_REG_ADDR);
	localparam logic [2:0] REG_DATA = 3'(`PPU_REG_DATA);

	ppu_addr_t  vaddr;
	ppu_addr_t  step;
	logic       addr_lo_next; // Next ADDR write fills the low byte
	logic [7:0] rbuf;         // VRAM read buffer
	logic [7:0] rd_q;
	logic       pal_rd_q;
	logic       refill_q;
	logic       vblank_flag;
	logic       in_vblank_q;
	logic       data_acc;
	logic       addr_is_pal;

	assign data_acc = cs && (reg_addr == REG_DATA);
	assign addr_is_pal = {2'b00, vaddr} >= `PPU_PAL_BASE;
	assign step = ctrl.incr32 ? ppu_addr_t'(32) : ppu_addr_t'(1);

	// Current address goes out every cycle, we only on a DATA write
	assign cpu_req = '{addr: vaddr, we: data_acc && we, wdata: cpu_data_in};

	assign cpu_data_out = pal_rd_q ? {2'b00, pal_rdata} : rd_q; // Palette skips the buffer
	assign nmi = ctrl.nmi_en && vblank_flag;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl <= '0;
			mask <= '0;
			vaddr <= '0;
			addr_lo_next <= 1'b0;
			rd_q <= '0;
			pal_rd_q <= 1'b0;
			refill_q <= 1'b0;
			vblank_flag <= 1'b0;
			in_vblank_q <= 1'b0;
		end else begin
			in_vblank_q <= beam.in_vblank;
			pal_rd_q <= 1'b0;
			refill_q <= 1'b0;
			if (pal_rd_q) begin
				rd_q <= {2'b00, pal_rdata}; // Hold palette word until next read
			end
			if (beam.vc == 9'd0) begin
				vblank_flag <= 1'b0;
			end
			if (cs && we) begin
				case (reg_addr)
					REG_CTRL: ctrl <= ctrl_t'(cpu_data_in);
					REG_MASK: mask <= mask_t'(cpu_data_in);
					REG_ADDR: begin
						if (addr_lo_next) begin
							vaddr[7:0] <= cpu_data_in;
						end else begin
							vaddr[13:8] <= cpu_data_in[5:0];
						end
						addr_lo_next <= !addr_lo_next;
					end
					default: ;
				endcase
			end else if (cs) begin
				case (reg_addr)
					REG_STATUS: begin
						rd_q <= {vblank_flag, 7'b0000000};
						vblank_flag <= 1'b0;
						addr_lo_next <= 1'b0;
					end
					REG_DATA: begin
						if (addr_is_pal && cpu_owns) begin
							pal_rd_q <= 1'b1;
						end else begin
							rd_q <= rbuf; // Previous buffer contents
							refill_q <= cpu_owns && !addr_is_pal;
						end
					end
					default: rd_q <= '0;
				endcase
			end
			if (data_acc) begin
				vaddr <= vaddr + step; // Steps even when the access is dropped
			end
			if (beam.in_vblank && !in_vblank_q) begin
				vblank_flag <= 1'b1;
			end
		end
	end

	// RAM word arrives one cycle after the strobe
	always_ff @(posedge clk) begin
		if (refill_q) begin
			rbuf <= vram_rdata;
		end
	end

endmodule

`default_nettype wire

//--- render/ppu_render.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_render (
	input  logic                     clk,
	input  logic                     rst_n,
	input  ppu_video_pkg::beam_t     beam,
	input  ppu_bus_pkg::ctrl_t       ctrl,
	input  logic [7:0]               vram_rdata,
	output ppu_bus_pkg::ppu_addr_t   vram_addr,
	output ppu_video_pkg::pal_addr_t pix_pal
);

	localparam logic [8:0] PREFETCH_X = 9'(`PPU_H_TOTAL - 16);
	localparam logic [8:0] LAST_LINE = 9'(`PPU_V_TOTAL - 1);

	logic        prefetch;
	logic [8:0]  fx;          // Pixel column being fetched
	logic [8:0]  fy;          // Line being fetched
	logic [2:0]  phase;
	logic [7:0]  attr_sh;
	logic [7:0]  name_q;
	logic [1:0]  attr_q;
	logic [7:0]  pat_lo_q;
	logic [15:0] sr_lo;
	logic [15:0] sr_hi;
	logic [1:0]  at_cur;      // Pair for the tile on screen
	logic [1:0]  at_nxt;
	logic [1:0]  px;

	assign phase = beam.hc[2:0];

	// Fetch runs 16 pixels ahead, the last two slots prefetch the next line
	always_comb begin
		prefetch = beam.hc >= PREFETCH_X;
		if (prefetch) begin
			fx = beam.hc - PREFETCH_X;
			fy = (beam.vc == LAST_LINE) ? 9'd0 : beam.vc + 9'd1;
		end else begin
			fx = beam.hc + 9'd16;
			fy = beam.vc;
		end
	end

	always_comb begin
		case (phase[2:1])
			2'd0: vram_addr = {1'b1, 3'b000, fy[7:3], fx[7:3]};        // Name table
			2'd1: vram_addr = {4'b1000, 4'b1111, fy[7:5], fx[7:5]};    // Attribute table
			2'd2: vram_addr = {1'b0, ctrl.bg_table, name_q, 1'b0, fy[2:0]};
			default: vram_addr = {1'b0, ctrl.bg_table, name_q, 1'b1, fy[2:0]};
		endcase
	end

	// Quadrant picks one of four pairs
	assign attr_sh = vram_rdata >> {fy[4], fx[4], 1'b0};

	always_ff @(posedge clk) begin
		case (phase)
			3'd1: name_q <= vram_rdata;
			3'd3: attr_q <= attr_sh[1:0];
			3'd5: pat_lo_q <= vram_rdata;
			default: ;
		endcase
		if (phase == 3'd7) begin
			sr_lo <= {sr_lo[14:7], pat_lo_q};
			sr_hi <= {sr_hi[14:7], vram_rdata}; // High plane straight from RAM
			at_nxt <= attr_q;
			at_cur <= at_nxt;
		end else begin
			sr_lo <= {sr_lo[14:0], 1'b0};
			sr_hi <= {sr_hi[14:0], 1'b0};
		end
	end

	assign px = {sr_hi[15], sr_lo[15]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_pal <= '0;
		end else begin
			pix_pal <= (px == 2'b00) ? 5'd0 : {1'b0, at_cur, px}; // Transparent uses entry 0
		end
	end

endmodule

`default_nettype wire

//--- src/video_out.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module video_out (
	input  logic                     clk,
	input  logic                     rst_n,
	input  ppu_video_pkg::pal_addr_t pix_pal,
	input  ppu_video_pkg::color_t    pal_rdata,
	output ppu_video_pkg::beam_t     beam,
	output ppu_video_pkg::pal_addr_t pal_addr,
	output ppu_video_pkg::vga_t      vga,
	output logic                     vga_clk
);

	import ppu_video_pkg::*;

	localparam logic [8:0] H_LAST = 9'(`PPU_H_TOTAL - 1);
	localparam logic [8:0] V_LAST = 9'(`PPU_V_TOTAL - 1);
	localparam logic [8:0] H_VIS = 9'(`PPU_H_VISIBLE);
	localparam logic [8:0] V_VIS = 9'(`PPU_V_VISIBLE);
	localparam logic [8:0] HS_START = 9'(`PPU_HS_START);
	localparam logic [8:0] HS_END = 9'(`PPU_HS_START + `PPU_HS_LEN);
	localparam logic [8:0] VS_START = 9'(`PPU_VS_START);
	localparam logic [8:0] VS_END = 9'(`PPU_VS_START + `PPU_VS_LEN);

	typedef struct packed {
		logic hs;
		logic vs;
		logic blank_n;
	} sync_t;

	localparam sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0};

	logic [8:0] hc;
	logic [8:0] vc;
	sync_t      sync_now;
	sync_t      sync_d1;  // Lines up with pix_pal
	sync_t      sync_d2;  // Lines up with pal_rdata
	rgb_t       expand;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hc <= '0;
			vc <= '0;
		end else if (hc == H_LAST) begin
			hc <= '0;
			vc <= (vc == V_LAST) ? 9'd0 : vc + 9'd1;
		end else begin
			hc <= hc + 9'd1;
		end
	end

	// Last line hands the memories back so the renderer can prefetch line 0
	always_comb begin
		beam.hc = hc;
		beam.vc = vc;
		beam.visible = (hc < H_VIS) && (vc < V_VIS);
		beam.in_vblank = (vc >= V_VIS) && (vc < V_LAST);
		sync_now.hs = !((hc >= HS_START) && (hc < HS_END));
		sync_now.vs = !((vc >= VS_START) && (vc < VS_END));
		sync_now.blank_n = beam.visible;
	end

	assign pal_addr = pix_pal;

	// Each 2-bit channel repeated to 8 bits
	assign expand.r = {4{pal_rdata[5:4]}};
	assign expand.g = {4{pal_rdata[3:2]}};
	assign expand.b = {4{pal_rdata[1:0]}};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= SYNC_IDLE;
			sync_d2 <= SYNC_IDLE;
			vga <= '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0, rgb: '0};
			vga_clk <= 1'b0;
		end else begin
			sync_d1 <= sync_now;
			sync_d2 <= sync_d1;
			vga.hs <= sync_d2.hs;
			vga.vs <= sync_d2.vs;
			vga.blank_n <= sync_d2.blank_n;
			vga.rgb <= sync_d2.blank_n ? expand : '0; // Black outside the picture
			vga_clk <= !vga_clk;
		end
	end

endmodule

`default_nettype wire

//--- src/ppu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cs,
	input  logic                we,
	input  logic [2:0]          reg_addr,
	input  logic [7:0]          cpu_data_in,
	output logic [7:0]          cpu_data_out,
	output ppu_video_pkg::vga_t vga,
	output logic                vga_clk,
	output logic                nmi
);

	import ppu_bus_pkg::*;
	import ppu_video_pkg::*;

	beam_t      beam;
	ctrl_t      ctrl;
	mask_t      mask;
	mem_req_t   cpu_req;
	ppu_addr_t  render_addr;
	ppu_addr_t  vram_addr;
	logic [7:0] vram_rdata;
	logic       vram_we;
	pal_addr_t  pix_pal;
	pal_addr_t  vid_pal_addr;
	pal_addr_t  pal_addr;
	color_t     pal_rdata;
	logic       pal_we;
	logic       cpu_owns;
	logic       cpu_is_pal;

	assign cpu_owns = beam.in_vblank || !mask.show_bg; // Safe window for CPU access
	assign cpu_is_pal = {2'b00, cpu_req.addr} >= `PPU_PAL_BASE;

	// Requests outside the CPU window are dropped
	assign vram_addr = cpu_owns ? cpu_req.addr : render_addr;
	assign vram_we = cpu_owns && cpu_req.we && !cpu_is_pal;
	assign pal_addr = cpu_owns ? cpu_req.addr[4:0] : vid_pal_addr;
	assign pal_we = cpu_owns && cpu_req.we && cpu_is_pal;

	ppu_reg u_reg (
		.clk(clk), .rst_n(rst_n), .cs(cs), .we(we), .reg_addr(reg_addr),
		.cpu_data_in(cpu_data_in), .beam(beam), .cpu_owns(cpu_owns),
		.vram_rdata(vram_rdata), .pal_rdata(pal_rdata), .cpu_data_out(cpu_data_out),
		.cpu_req(cpu_req), .ctrl(ctrl), .mask(mask), .nmi(nmi)
	);

	ppu_render u_render (
		.clk(clk), .rst_n(rst_n), .beam(beam), .ctrl(ctrl), .vram_rdata(vram_rdata),
		.vram_addr(render_addr), .pix_pal(pix_pal)
	);

	video_out u_video (
		.clk(clk), .rst_n(rst_n), .pix_pal(pix_pal), .pal_rdata(pal_rdata),
		.beam(beam), .pal_addr(vid_pal_addr), .vga(vga), .vga_clk(vga_clk)
	);

	ppu_ram #(.word_t(logic [7:0]), .DEPTH(`PPU_VRAM_DEPTH)) u_vram (
		.clk(clk), .addr(vram_addr), .we(vram_we), .wdata(cpu_req.wdata), .rdata(vram_rdata)
	);

	ppu_ram #(.word_t(color_t), .DEPTH(`PPU_PAL_DEPTH)) u_pal (
		.clk(clk), .addr(pal_addr), .we(pal_we), .wdata(color_t'(cpu_req.wdata[5:0])),
		.rdata(pal_rdata)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module tb_clock #(
	parameter int HALF_PERIOD = 4,  // 8 ns clock
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = !clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/ppu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "ppu_settings.svh"

module ppu_tb;

	import ppu_video_pkg::*;

	localparam int SEL_NMI = 0;
	localparam int SEL_HS = 1;
	localparam int SEL_VS = 2;
	localparam int SEL_BLANK = 3;
	localparam int FRAME_CYCLES = `PPU_H_TOTAL * `PPU_V_TOTAL;
	localparam logic [2:0] R_CTRL = 3'(`PPU_REG_CTRL);
	localparam logic [2:0] R_MASK = 3'(`PPU_REG_MASK);
	localparam logic [2:0] R_STATUS = 3'(`PPU_REG_STATUS);
	localparam logic [2:0] R_ADDR = 3'(`PPU_REG_ADDR);
	localparam logic [2:0] R_DATA = 3'(`PPU_REG_DATA);

	logic        clk;
	logic        rst_n;
	logic        cs = 1'b0;
	logic        we = 1'b0;
	logic [2:0]  reg_addr = '0;
	logic [7:0]  cpu_data_in = '0;
	logic [7:0]  cpu_data_out;
	vga_t        vga;
	logic        vga_clk;
	logic        nmi;
	logic [15:0] lfsr = 16'd8807;
	logic [7:0]  ref_vram [`PPU_VRAM_DEPTH]; // Expected memory contents
	logic [5:0]  ref_pal [`PPU_PAL_DEPTH];
	logic [7:0]  rd;
	logic [7:0]  old0;
	logic [7:0]  old1;
	int          n;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	ppu_top u_dut (
		.clk(clk), .rst_n(rst_n), .cs(cs), .we(we), .reg_addr(reg_addr),
		.cpu_data_in(cpu_data_in), .cpu_data_out(cpu_data_out), .vga(vga),
		.vga_clk(vga_clk), .nmi(nmi)
	);

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic expect_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			fail_stop($sformatf("Mismatch %s expected %0h actual %0h", name, expected, actual));
	endtask

	blank_black: assert property (@(posedge clk) disable iff (!rst_n)
		!vga.blank_n |-> vga.rgb == '0)
		else fail_stop("rgb is not black during blanking");

	// Pixel clock runs at half the system clock
	vga_clk_toggle: assert property (@(posedge clk)
		rst_n && $past(rst_n) |-> vga_clk != $past(vga_clk))
		else fail_stop("vga_clk does not toggle on every clock");

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	function automatic logic level_of(input int sel);
		case (sel)
			SEL_NMI: return nmi;
			SEL_HS: return vga.hs;
			SEL_VS: return vga.vs;
			default: return vga.blank_n;
		endcase
	endfunction

	task automatic write_reg(input logic [2:0] ra, input logic [7:0] d);
		@(posedge clk);
		cs <= 1'b1;
		we <= 1'b1;
		reg_addr <= ra;
		cpu_data_in <= d;
		@(posedge clk);
		cs <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic read_reg(input logic [2:0] ra, output logic [7:0] d);
		@(posedge clk);
		cs <= 1'b1;
		reg_addr <= ra;
		@(posedge clk);
		cs <= 1'b0;
		@(negedge clk);
		d = cpu_data_out; // Valid the cycle after the strobe
	endtask

	task automatic set_addr(input logic [13:0] a);
		write_reg(R_ADDR, {2'b00, a[13:8]});
		write_reg(R_ADDR, a[7:0]);
	endtask

	function automatic void model_write(input int a, input logic [7:0] d);
		if (a >= `PPU_PAL_BASE) begin
			ref_pal[a % `PPU_PAL_DEPTH] = d[5:0];
		end else begin
			ref_vram[a] = d;
		end
	endfunction

	task automatic fill_seq(input int base, input int count, input int step);
		logic [7:0] d;
		write_reg(R_CTRL, (step == 32) ? 8'h04 : 8'h00);
		set_addr(14'(base));
		for (int i = 0; i < count; i++) begin
			d = random_byte();
			write_reg(R_DATA, d);
			model_write(base + step * i, d);
		end
	endtask

	task automatic check_seq(input int base, input int count, input int step, input string name);
		logic [7:0] d;
		int a;
		write_reg(R_CTRL, (step == 32) ? 8'h04 : 8'h00);
		set_addr(14'(base));
		if (base < `PPU_PAL_BASE) begin
			read_reg(R_DATA, d); // Primes the read buffer
		end
		for (int i = 0; i < count; i++) begin
			a = base + step * i;
			read_reg(R_DATA, d);
			expect_eq(name, (a >= `PPU_PAL_BASE) ? {2'b00, ref_pal[a % 32]} : ref_vram[a], d);
		end
	endtask

	// Expected colour of one screen pixel from the reference memories
	function automatic logic [23:0] pixel_rgb(input int x, input int y);
		logic [7:0] tile;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] attr;
		logic [1:0] px;
		logic [1:0] pair;
		logic [5:0] c;
		tile = ref_vram[16'h2000 + 32 * (y / 8) + x / 8];
		lo = ref_vram[16 * tile + y % 8];
		hi = ref_vram[16 * tile + y % 8 + 8];
		px = {hi[7 - x % 8], lo[7 - x % 8]};
		attr = ref_vram[16'h23C0 + 8 * (y / 32) + x / 32];
		pair = 2'((attr >> (4 * ((y / 16) % 2) + 2 * ((x / 16) % 2))) & 8'h03);
		c = (px == 2'b00) ? ref_pal[0] : ref_pal[{pair, px}];
		return {{4{c[5:4]}}, {4{c[3:2]}}, {4{c[1:0]}}};
	endfunction

	task automatic wait_level(input int sel, input logic level, input int limit, input string what);
		int count;
		count = 0;
		do begin
			@(negedge clk);
			count++;
			if (count > limit) begin
				fail_stop($sformatf("Timeout waiting for %s", what));
			end
		end while (level_of(sel) !== level);
	endtask

	task automatic measure_low(input int sel, input string what, output int count);
		wait_level(sel, 1'b1, 2 * FRAME_CYCLES, what);
		wait_level(sel, 1'b0, 2 * FRAME_CYCLES, what);
		count = 0;
		while (level_of(sel) === 1'b0) begin
			count++;
			@(negedge clk);
			if (count > 8 * `PPU_H_TOTAL) begin
				fail_stop($sformatf("%s pulse never ends", what));
			end
		end
	endtask

	// Walks one frame from the blank_n edges starting after vsync
	task automatic scan_frame(input bit pixels);
		int gap;
		wait_level(SEL_VS, 1'b0, 2 * FRAME_CYCLES, "vertical sync");
		for (int y = 0; y < `PPU_V_VISIBLE; y++) begin
			wait_level(SEL_BLANK, 1'b1, (y == 0) ? 30 * `PPU_H_TOTAL : `PPU_H_TOTAL,
				"start of a visible line");
			for (int x = 0; x < `PPU_H_VISIBLE; x++) begin
				expect_eq("blank_n inside line", 1, vga.blank_n);
				if (pixels) begin
					expect_eq($sformatf("pixel %0d,%0d", x, y), pixel_rgb(x, y), vga.rgb);
				end
				@(negedge clk);
			end
			expect_eq("line length", 0, vga.blank_n);
		end
		gap = 0;
		while (vga.vs !== 1'b0) begin
			@(negedge clk);
			gap++;
			if (vga.blank_n) begin
				fail_stop("Frame has more than the expected visible lines");
			end
			if (gap > 8 * `PPU_H_TOTAL) begin
				fail_stop("Timeout waiting for vertical sync after the frame");
			end
		end
	endtask

	initial begin
		repeat (3) @(negedge clk);
		expect_eq("reset nmi", 0, nmi);
		expect_eq("reset blank_n", 0, vga.blank_n);
		expect_eq("reset hs", 1, vga.hs);
		expect_eq("reset vs", 1, vga.vs);
		expect_eq("reset rgb", 0, vga.rgb);
		n = 0;
		while (!rst_n) begin
			@(negedge clk);
			n++;
			if (n > 100) begin
				fail_stop("Reset is never released");
			end
		end
		write_reg(R_CTRL, 8'h80); // nmi_en
		wait_level(SEL_NMI, 1'b1, 2 * FRAME_CYCLES, "nmi at vertical blank");
		read_reg(R_STATUS, rd);
		expect_eq("status in vblank", 8'h80, rd);
		read_reg(R_STATUS, rd);
		expect_eq("status second read", 8'h00, rd);
		expect_eq("nmi after status read", 0, nmi);
		fill_seq(16'h0400, 16, 1);
		check_seq(16'h0400, 16, 1, "vram step 1");
		fill_seq(16'h0800, 16, 32);
		check_seq(16'h0800, 16, 32, "vram step 32");
		fill_seq(`PPU_PAL_BASE, 32, 1);
		check_seq(`PPU_PAL_BASE, 32, 1, "palette");
		fill_seq(16'h0000, 4096, 1); // Pattern table 0
		fill_seq(16'h2000, 960, 1);
		fill_seq(16'h23C0, 64, 1);
		fill_seq(`PPU_PAL_BASE, 32, 1);
		write_reg(R_MASK, 8'h08); // show_bg
		scan_frame(1'b1);
		measure_low(SEL_HS, "hsync", n);
		expect_eq("hsync width", `PPU_HS_LEN, n);
		measure_low(SEL_VS, "vsync", n);
		expect_eq("vsync width", `PPU_VS_LEN * `PPU_H_TOTAL, n);
		// Writes during the picture are dropped but step the address
		set_addr(14'h0400);
		wait_level(SEL_BLANK, 1'b1, 2 * FRAME_CYCLES, "visible region");
		old0 = ref_vram[16'h0400];
		old1 = ref_vram[16'h0401];
		write_reg(R_DATA, ~old0);
		write_reg(R_DATA, ~old1);
		wait_level(SEL_VS, 1'b0, 2 * FRAME_CYCLES, "vertical blank");
		rd = random_byte();
		write_reg(R_DATA, rd);
		model_write(16'h0402, rd);
		check_seq(16'h0400, 3, 1, "ownership");
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/ppu_bus_pkg.sv
common/ppu_video_pkg.sv
src/ppu_ram.sv
ppu_reg/ppu_reg.sv
render/ppu_render.sv
src/video_out.sv
src/ppu_top.sv
dv/tb_clock.sv
dv/ppu_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module ppu_tb
	-./obj_dir/Vppu_tb > sim.log 2>&1
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
